// File: cpuPkg.sv
// ----------------------------------------------------------
// widths, opcodes, field positions and stage bundles of the core
// immediate extension puts bit 15 at bit 31 with bits 30..15 zero
// ----------------------------------------------------------
package cpuPkg;

   localparam int dataWidth   = 32;
   localparam int addrWidth   = 7;
   localparam int memDepth    = 128;
   localparam int regCount    = 32;
   localparam int regIdxWidth = $clog2(regCount);
   localparam int opWidth     = 6;
   localparam int immWidth    = 16;

   typedef logic [dataWidth-1:0]   wordT;
   typedef logic [addrWidth-1:0]   pcT;
   typedef logic [regIdxWidth-1:0] regIdxT;
   typedef logic [opWidth-1:0]     opcodeT;

   // opcodes, any other value does nothing
   localparam opcodeT opHalt = 6'd0;
   localparam opcodeT opAdd  = 6'd1;
   localparam opcodeT opSub  = 6'd2;
   localparam opcodeT opAnd  = 6'd3;
   localparam opcodeT opOr   = 6'd4;
   localparam opcodeT opAddi = 6'd5;
   localparam opcodeT opJ    = 6'd8;
   localparam opcodeT opJr   = 6'd9;
   localparam opcodeT opBgt  = 6'd10;

   // lowest bit of each instruction field
   localparam int opLsb     = 26;   // 31..26
   localparam int rdLsb     = 21;   // 25..21
   localparam int rsLsb     = 16;   // 20..16
   localparam int rtLsb     = 11;   // 15..11
   localparam int immLsb    = 0;    // 15..0
   localparam int targetLsb = 0;    // 6..0, jump target or branch offset

   // fetching here ends the program
   localparam pcT lastAddr = pcT'(memDepth - 1);

   typedef struct packed {
      logic valid;
      pcT   pc;
      wordT instr;
   } fetchBundleT;

   typedef struct packed {
      logic   valid;
      pcT     pc;
      opcodeT op;
      regIdxT rd;
      wordT   opA;      // rs contents
      wordT   opB;      // rt contents
      wordT   imm;      // already extended
      pcT     target;
   } decodeBundleT;

   typedef struct packed {
      logic taken;
      pcT   target;
   } redirectT;

   typedef struct packed {
      logic   valid;
      regIdxT dest;
      wordT   data;
   } wbBundleT;

endpackage

// File: instructionMemory.sv
// ----------------------------------------------------------
// 128-word instruction store, every word cleared by reset
// read data appears one clock after the address
// ----------------------------------------------------------
`timescale 1ns/1ps

module instructionMemory import cpuPkg::*; (
   input  logic clk,
   input  logic reset,
   input  logic writeEnable,
   input  pcT   writeAddress,
   input  wordT writeData,
   input  pcT   readAddress,
   output wordT readData
);

   wordT mem [memDepth];

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < memDepth; i++) begin
            mem[i] <= '0;
         end
         readData <= '0;
      end else begin
         if (writeEnable) begin
            mem[writeAddress] <= writeData;   // loader port
         end
         // old word is returned when reading the address being written
         readData <= mem[readAddress];
      end
   end

endmodule

// File: programControl.sv
// ----------------------------------------------------------
// fetch stage: pc, next-address choice and instruction memory
// memory loads only while suspend is high, pc holds at address 127
// ----------------------------------------------------------
`timescale 1ns/1ps

module programControl import cpuPkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  logic        suspend,
   input  logic        loadEnable,
   input  pcT          loadAddress,
   input  wordT        loadData,
   input  redirectT    redirect,
   input  logic        halt,
   output fetchBundleT fetch,
   output logic        halted
);

   pcT   pc;
   pcT   pcNext;
   logic wasSuspended;   // first cycle after suspend falls
   logic hold;
   logic issue;
   logic fetchValid;
   pcT   fetchPc;
   wordT memData;

   instructionMemory imem_i (
      .clk          (clk),
      .reset        (reset),
      .writeEnable  (loadEnable & suspend),
      .writeAddress (loadAddress),
      .writeData    (loadData),
      .readAddress  (pc),
      .readData     (memData)
   );

   // pc freezes while loading, right after loading, and once stopped
   assign hold = suspend | wasSuspended | halted | halt | (pc == lastAddr);

   // a read is a real instruction only when nothing kills or stops it
   // lastAddr itself still issues so its zero word can halt the core
   assign issue = ~(suspend | wasSuspended | halted | halt | redirect.taken);

   always_comb begin
      if (redirect.taken) begin
         pcNext = redirect.target;   // wins even while suspended
      end else if (hold) begin
         pcNext = pc;
      end else begin
         pcNext = pc + 1'b1;
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         pc           <= '0;
         wasSuspended <= 1'b0;
         fetchValid   <= 1'b0;
         fetchPc      <= '0;
      end else begin
         pc           <= pcNext;
         wasSuspended <= suspend;
         fetchValid   <= issue;
         fetchPc      <= pc;      // tag travels with the memory read
      end
   end

   // halted rises the cycle after the halt pulse
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         halted <= 1'b0;
      end else if (suspend) begin
         halted <= 1'b0;
      end else if (halt) begin
         halted <= 1'b1;
      end
   end

   // end of program reads as an all-zero word
   always_comb begin
      fetch.valid = fetchValid;
      fetch.pc    = fetchPc;
      fetch.instr = (fetchPc == lastAddr) ? '0 : memData;
   end

endmodule

// File: registerFile.sv
// ----------------------------------------------------------
// 32 registers, r0 always reads zero
// a read of the register being written returns the new value
// ----------------------------------------------------------
`timescale 1ns/1ps

module registerFile import cpuPkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  regIdxT   readIdxA,
   input  regIdxT   readIdxB,
   output wordT     readA,
   output wordT     readB,
   input  wbBundleT wb
);

   wordT regs [regCount];
   logic writing;

   assign writing = wb.valid && (wb.dest != '0);   // r0 writes dropped

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (writing) begin
         regs[wb.dest] <= wb.data;
      end
   end

   // write-through bypass
   assign readA = (writing && (wb.dest == readIdxA)) ? wb.data : regs[readIdxA];
   assign readB = (writing && (wb.dest == readIdxB)) ? wb.data : regs[readIdxB];

endmodule

// File: decodeStage.sv
// ----------------------------------------------------------
// decode: field split, operand read and immediate extension
// a redirect from execute turns the incoming item into a bubble
// ----------------------------------------------------------
`timescale 1ns/1ps

module decodeStage import cpuPkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  fetchBundleT  fetch,
   input  redirectT     redirect,
   output regIdxT       readIdxA,
   output regIdxT       readIdxB,
   input  wordT         readA,
   input  wordT         readB,
   output decodeBundleT decoded
);

   opcodeT              op;
   regIdxT              rd;
   logic [immWidth-1:0] immField;
   wordT                immExt;
   pcT                  target;

   always_comb begin
      op       = fetch.instr[opLsb +: opWidth];
      rd       = fetch.instr[rdLsb +: regIdxWidth];
      readIdxA = fetch.instr[rsLsb +: regIdxWidth];   // rs
      readIdxB = fetch.instr[rtLsb +: regIdxWidth];   // rt
      immField = fetch.instr[immLsb +: immWidth];
      target   = fetch.instr[targetLsb +: addrWidth];
   end

   // top immediate bit lands in bit 31, bits 30..15 stay zero
   always_comb begin
      immExt                 = '0;
      immExt[dataWidth-1]    = immField[immWidth-1];
      immExt[immWidth-2:0]   = immField[immWidth-2:0];
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         decoded <= '0;
      end else begin
         decoded.valid  <= fetch.valid & ~redirect.taken;
         decoded.pc     <= fetch.pc;
         decoded.op     <= op;
         decoded.rd     <= rd;
         decoded.opA    <= readA;
         decoded.opB    <= readB;
         decoded.imm    <= immExt;
         decoded.target <= target;
      end
   end

endmodule

// File: executeStage.sv
// ----------------------------------------------------------
// execute: ALU, control transfers and halt detection
// writeback is presented this cycle and committed at the next edge
// ----------------------------------------------------------
`timescale 1ns/1ps

module executeStage import cpuPkg::*; (
   input  logic         clk,
   input  logic         reset,
   input  decodeBundleT decoded,
   output redirectT     redirect,
   output logic         halt,
   output wbBundleT     wb
);

   logic killNext;       // item right behind a halt never runs
   logic live;
   logic isArith;
   wordT result;
   wordT diff;
   pcT   branchTarget;

   assign live = decoded.valid & ~killNext;
   assign diff = decoded.opA - decoded.opB;

   // offset is relative to the instruction after the branch
   assign branchTarget = decoded.pc + decoded.target + 1'b1;

   always_comb begin
      result          = '0;
      isArith         = 1'b0;
      redirect.taken  = 1'b0;
      redirect.target = decoded.target;
      case (decoded.op)
         opAdd: begin
            result  = decoded.opA + decoded.opB;
            isArith = 1'b1;
         end
         opSub: begin
            result  = diff;
            isArith = 1'b1;
         end
         opAnd: begin
            result  = decoded.opA & decoded.opB;
            isArith = 1'b1;
         end
         opOr: begin
            result  = decoded.opA | decoded.opB;
            isArith = 1'b1;
         end
         opAddi: begin
            result  = decoded.opA + decoded.imm;
            isArith = 1'b1;
         end
         opJ: begin
            redirect.taken = live;
         end
         opJr: begin
            redirect.taken  = live;
            redirect.target = decoded.opA[addrWidth-1:0];
         end
         opBgt: begin
            redirect.taken  = live & ~diff[dataWidth-1];   // rs - rt not negative
            redirect.target = branchTarget;
         end
         default: ;   // halt and unknown opcodes
      endcase
   end

   assign halt = live && (decoded.op == opHalt);

   always_comb begin
      wb.valid = live & isArith;
      wb.dest  = decoded.rd;
      wb.data  = result;
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         killNext <= 1'b0;
      end else begin
         killNext <= halt;
      end
   end

endmodule

// File: cpuTop.sv
// ----------------------------------------------------------
// three-stage core top, program loaded while suspend is high
// trace shows every register write including writes to r0
// ----------------------------------------------------------
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
   input  logic   clk,
   input  logic   reset,
   input  logic   suspend,
   input  logic   loadEnable,
   input  pcT     loadAddress,
   input  wordT   loadData,
   output logic   halted,
   output logic   traceValid,
   output regIdxT traceDest,
   output wordT   traceData
);

   fetchBundleT  fetch;
   decodeBundleT decoded;
   redirectT     redirect;
   wbBundleT     wb;
   logic         halt;
   regIdxT       readIdxA;
   regIdxT       readIdxB;
   wordT         readA;
   wordT         readB;

   programControl fetch_i (
      .clk         (clk),
      .reset       (reset),
      .suspend     (suspend),
      .loadEnable  (loadEnable),
      .loadAddress (loadAddress),
      .loadData    (loadData),
      .redirect    (redirect),
      .halt        (halt),
      .fetch       (fetch),
      .halted      (halted)
   );

   decodeStage decode_i (
      .clk      (clk),
      .reset    (reset),
      .fetch    (fetch),
      .redirect (redirect),
      .readIdxA (readIdxA),
      .readIdxB (readIdxB),
      .readA    (readA),
      .readB    (readB),
      .decoded  (decoded)
   );

   registerFile regs_i (
      .clk      (clk),
      .reset    (reset),
      .readIdxA (readIdxA),
      .readIdxB (readIdxB),
      .readA    (readA),
      .readB    (readB),
      .wb       (wb)
   );

   executeStage execute_i (
      .clk      (clk),
      .reset    (reset),
      .decoded  (decoded),
      .redirect (redirect),
      .halt     (halt),
      .wb       (wb)
   );

   assign traceValid = wb.valid;
   assign traceDest  = wb.dest;
   assign traceData  = wb.data;

endmodule

// File: cpuTop_chk.sv
// ----------------------------------------------------------
// pipeline control assertions, bound into fetch and execute
// each binding connects what its host owns, the rest is tied idle
// ----------------------------------------------------------
`timescale 1ns/1ps

module pipelineChecks import cpuPkg::*; (
   input logic clk,
   input logic reset,
   input logic suspend,
   input pcT   pc,
   input logic redirectTaken,
   input logic halted,
   input logic fetchValid,
   input logic wbValid
);

   int failures = 0;   // summed into the testbench summary

   // a redirect still moves the pc while suspended
   pcHold: assert property (@(posedge clk) disable iff (!reset)
      suspend && !redirectTaken |=> pc == $past(pc))
      else begin
         failures++;
         $error("pc moved while suspended");
      end

   killAfterRedirect: assert property (@(posedge clk) disable iff (!reset)
      redirectTaken |=> !wbValid)
      else begin
         failures++;
         $error("writeback valid right after a redirect");
      end

   haltedSticky: assert property (@(posedge clk) disable iff (!reset)
      halted && !suspend |=> halted)
      else begin
         failures++;
         $error("halted fell without suspend");
      end

   noFetchHalted: assert property (@(posedge clk) disable iff (!reset)
      halted |-> !fetchValid)
      else begin
         failures++;
         $error("fetch valid while halted");
      end

endmodule

bind programControl pipelineChecks ctrlChk_i (
   .clk           (clk),
   .reset         (reset),
   .suspend       (suspend),
   .pc            (pc),
   .redirectTaken (redirect.taken),
   .halted        (halted),
   .fetchValid    (fetch.valid),
   .wbValid       (1'b0)
);

bind executeStage pipelineChecks execChk_i (
   .clk           (clk),
   .reset         (reset),
   .suspend       (1'b0),
   .pc            ('0),
   .redirectTaken (redirect.taken),
   .halted        (1'b0),
   .fetchValid    (1'b0),
   .wbValid       (wb.valid)
);

// File: cpuTb.sv
// ----------------------------------------------------------
// loads each program while suspended, runs it to halt, checks the trace
// expected writes come from an instruction-set model, r0 writes are ignored
// ----------------------------------------------------------
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

   localparam int testCount   = 5;
   localparam int runLimit    = 400;             // cycles per program run
   localparam int setupCycles = memDepth + 40;   // reset and loading
   localparam int cycleLimit  = testCount * (runLimit + setupCycles);

   logic   clk;
   logic   reset;
   logic   suspend;
   logic   loadEnable;
   pcT     loadAddress;
   wordT   loadData;
   logic   halted;
   logic   traceValid;
   regIdxT traceDest;
   wordT   traceData;

   wordT   prog [memDepth];   // program image for loader and model
   regIdxT expDest [$];
   wordT   expData [$];
   string  testName = "none";
   int     seed = 24609;
   int     cycles = 0;
   int     valueErrors = 0;
   int     eventErrors = 0;
   int     assertErrors;
   opcodeT arithOps [4] = '{opAdd, opSub, opAnd, opOr};

   cpuTop dut_i (
      .clk         (clk),
      .reset       (reset),
      .suspend     (suspend),
      .loadEnable  (loadEnable),
      .loadAddress (loadAddress),
      .loadData    (loadData),
      .halted      (halted),
      .traceValid  (traceValid),
      .traceDest   (traceDest),
      .traceData   (traceData)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic wordT instr(opcodeT op, regIdxT rd, regIdxT rs, logic [15:0] low);
      return {op, rd, rs, low};
   endfunction

   // instruction-set model, fills the expected write queues
   function automatic void runModel();
      wordT regs [regCount];
      wordT word;
      wordT a;
      wordT b;
      wordT diff;
      wordT result;
      logic writes;
      pcT   pc;
      foreach (regs[i]) regs[i] = '0;
      expDest.delete();
      expData.delete();
      pc = '0;
      for (int steps = 0; steps < runLimit; steps++) begin
         word = (pc == lastAddr) ? '0 : prog[pc];   // end address reads as zero
         if (word[31:26] == opHalt) break;
         a      = regs[word[20:16]];
         b      = regs[word[15:11]];
         diff   = a - b;
         writes = 1'b1;
         result = '0;
         case (word[31:26])
            opAdd:   result = a + b;
            opSub:   result = diff;
            opAnd:   result = a & b;
            opOr:    result = a | b;
            opAddi:  result = a + {word[15], 16'd0, word[14:0]};   // bit 15 moves to 31
            default: writes = 1'b0;
         endcase
         if (writes && word[25:21] != 5'd0) begin
            regs[word[25:21]] = result;
            expDest.push_back(word[25:21]);
            expData.push_back(result);
         end
         if (word[31:26] == opJ) pc = word[6:0];
         else if (word[31:26] == opJr) pc = a[6:0];
         else if (word[31:26] == opBgt && !diff[31]) pc = pc + word[6:0] + 7'd1;
         else pc = pc + 7'd1;
      end
   endfunction

   task automatic checkDest(string name, regIdxT expected, regIdxT actual);
      if (actual !== expected) begin
         $display("ERR %s dest expected r%0d actual r%0d", name, expected, actual);
         valueErrors++;
      end
   endtask

   task automatic checkData(string name, wordT expected, wordT actual);
      if (actual !== expected) begin
         $display("ERR %s data expected %h actual %h", name, expected, actual);
         valueErrors++;
      end
   endtask

   // trace is combinational from execute, stable at the falling edge
   always @(negedge clk) begin
      if (reset && traceValid && traceDest != '0) begin
         if (expDest.size() == 0) begin
            $display("%s: unexpected extra write r%0d = %h", testName, traceDest, traceData);
            eventErrors++;
         end else begin
            checkDest(testName, expDest.pop_front(), traceDest);
            checkData(testName, expData.pop_front(), traceData);
         end
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= cycleLimit) begin
         $display("timeout: run still going after %0d cycles", cycles);
         $display("Something failed");
         $finish;
      end
   end

   task automatic applyReset();
      @(posedge clk);
      #1 reset = 1'b0;
      repeat (16) @(posedge clk);
      #1 reset = 1'b1;
   endtask

   // zero words are skipped, reset has already cleared them
   task automatic loadProgram(int staleAt, wordT stale);
      for (int a = 0; a < memDepth; a++) begin
         if (prog[a] != '0 || a == staleAt) begin
            @(posedge clk);
            #1 loadEnable = 1'b1;
            loadAddress = pcT'(a);
            loadData    = (a == staleAt) ? stale : prog[a];
         end
      end
      @(posedge clk);
      #1 loadEnable = 1'b0;
   endtask

   // suspendAt > 0 pauses the run there and patches prog[patchAt]
   task automatic runTest(string name, int suspendAt, int patchAt, wordT stale);
      int waited;
      testName = name;
      @(posedge clk);
      #1 suspend = 1'b1;   // core stays idle through reset and loading
      applyReset();
      runModel();
      loadProgram(patchAt, stale);
      suspend = 1'b0;
      waited = 0;
      while (!halted && waited < runLimit) begin
         @(posedge clk);
         #1 waited++;
         if (waited == suspendAt) begin
            suspend     = 1'b1;
            loadEnable  = 1'b1;
            loadAddress = pcT'(patchAt);
            loadData    = prog[patchAt];
            @(posedge clk);
            #1 loadEnable = 1'b0;
            repeat (2) @(posedge clk);
            #1 suspend = 1'b0;
         end
      end
      if (!halted) begin
         $display("%s: core did not halt within %0d cycles", name, runLimit);
         eventErrors++;
      end
      repeat (6) @(posedge clk);   // nothing may trace after halt
      if (expDest.size() != 0) begin
         $display("%s: %0d expected writes never appeared", name, expDest.size());
         eventErrors++;
      end
   endtask

   task automatic clearProg();
      foreach (prog[i]) prog[i] = '0;
   endtask

   task automatic buildArith();
      regIdxT prevRd;
      regIdxT rd;
      regIdxT rt;
      int     pick;
      clearProg();
      prog[0] = instr(opAddi, 5'd1, 5'd0, 16'h9234);
      prevRd  = 5'd1;
      for (int i = 1; i < 16; i++) begin
         pick = $unsigned($random(seed)) % 5;
         rd   = regIdxT'($unsigned($random(seed)) % 8);   // r0 now and then
         rt   = regIdxT'($unsigned($random(seed)) % 8);
         if (pick == 4) prog[i] = instr(opAddi, rd, prevRd, 16'($random(seed)));
         else prog[i] = instr(arithOps[pick], rd, prevRd, {rt, 11'd0});
         prevRd = rd;   // next one depends on this result
      end
   endtask

   task automatic buildJump();
      clearProg();
      prog[0] = instr(opAddi, 5'd1, 5'd0, 16'd5);
      prog[1] = instr(opJ, 5'd0, 5'd0, 16'd4);
      prog[2] = instr(opAddi, 5'd2, 5'd0, 16'h0111);   // skipped
      prog[3] = instr(opAddi, 5'd2, 5'd0, 16'h0222);   // skipped
      prog[4] = instr(opAddi, 5'd3, 5'd0, 16'd9);
      prog[5] = instr(opAddi, 5'd4, 5'd0, 16'd8);
      prog[6] = instr(opJr, 5'd0, 5'd4, 16'd0);
      prog[7] = instr(opAddi, 5'd5, 5'd0, 16'h0333);   // skipped
      prog[8] = instr(opAdd, 5'd6, 5'd1, {5'd3, 11'd0});
   endtask

   task automatic buildBranch();
      clearProg();
      prog[0] = instr(opAddi, 5'd1, 5'd0, 16'd7);
      prog[1] = instr(opAddi, 5'd2, 5'd0, 16'd3);
      prog[2] = instr(opBgt, 5'd0, 5'd1, {5'd2, 4'd0, 7'd2});    // taken to 5
      prog[3] = instr(opAddi, 5'd3, 5'd0, 16'h0011);
      prog[4] = instr(opAddi, 5'd3, 5'd0, 16'h0022);
      prog[5] = instr(opBgt, 5'd0, 5'd2, {5'd1, 4'd0, 7'd3});    // falls through
      prog[6] = instr(opAddi, 5'd4, 5'd0, 16'h0044);
      prog[7] = instr(opBgt, 5'd0, 5'd1, {5'd1, 4'd0, 7'd1});    // equal operands, to 9
      prog[8] = instr(opAddi, 5'd3, 5'd0, 16'h0055);             // skipped
      prog[9] = instr(opSub, 5'd5, 5'd1, {5'd2, 11'd0});
   endtask

   task automatic buildEndAddr();
      clearProg();
      prog[0]   = instr(opAddi, 5'd1, 5'd0, 16'd1);
      prog[1]   = instr(opJ, 5'd0, 5'd0, 16'd123);
      prog[123] = instr(opAddi, 5'd2, 5'd1, 16'd2);
      prog[124] = instr(opAdd, 5'd3, 5'd2, {5'd1, 11'd0});
      prog[125] = instr(opAddi, 5'd4, 5'd0, 16'h8001);
      prog[126] = instr(opOr, 5'd5, 5'd3, {5'd4, 11'd0});
      prog[127] = instr(opAddi, 5'd6, 5'd0, 16'd77);   // never executes
   endtask

   // countdown loop, word 5 is patched while suspended
   task automatic buildLoop();
      clearProg();
      prog[0] = instr(opAddi, 5'd1, 5'd0, 16'd6);
      prog[1] = instr(opAddi, 5'd4, 5'd0, 16'd1);
      prog[2] = instr(opSub, 5'd1, 5'd1, {5'd4, 11'd0});
      prog[3] = instr(opAdd, 5'd2, 5'd2, {5'd1, 11'd0});
      prog[4] = instr(opBgt, 5'd0, 5'd1, {5'd4, 4'd0, 7'd125});   // back to 2
      prog[5] = instr(opAddi, 5'd6, 5'd2, 16'h0100);
   endtask

   initial begin
      reset       = 1'b0;
      suspend     = 1'b0;
      loadEnable  = 1'b0;
      loadAddress = '0;
      loadData    = '0;
      buildArith();
      runTest("arith", 0, -1, '0);
      buildJump();
      runTest("jump", 0, -1, '0);
      buildBranch();
      runTest("branch", 0, -1, '0);
      buildEndAddr();
      runTest("endAddr", 0, -1, '0);
      buildLoop();
      runTest("suspend", 10, 5, instr(opAddi, 5'd6, 5'd0, 16'h0bad));
      assertErrors = dut_i.fetch_i.ctrlChk_i.failures + dut_i.execute_i.execChk_i.failures;
      $display("errors: value %0d, trace event %0d, assertion %0d",
               valueErrors, eventErrors, assertErrors);
      if (valueErrors + eventErrors + assertErrors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// File: tb.f
cpuPkg.sv
instructionMemory.sv
programControl.sv
registerFile.sv
decodeStage.sv
executeStage.sv
cpuTop.sv
cpuTop_chk.sv
cpuTb.sv
